// ==== design/mc_defs.svh ====
// Address translation defines
`ifndef MC_DEFS_SVH
`define MC_DEFS_SVH

// width of the byte EVA and of store data.
`define MC_DATA_WIDTH 32

// width of the network word address.
`define MC_ADDR_WIDTH 28

// full mesh coordinates.
`define MC_X_CORD_WIDTH 7
`define MC_Y_CORD_WIDTH 7

// pod coordinates form the upper bits of a full coordinate.
`define MC_POD_X_CORD_WIDTH 3
`define MC_POD_Y_CORD_WIDTH 4

// position of a tile or vcache inside its pod.
`define MC_X_SUBCORD_WIDTH 4
`define MC_Y_SUBCORD_WIDTH 3

// vcache rows on each side of the pod.
`define MC_NUM_VCACHE_ROWS 1

// words per vcache line.
`define MC_VCACHE_BLOCK_WORDS 8

`endif

// ==== design/mc_dram_hash.sv ====
// DRAM address hash
`include "mc_defs.svh"

module mc_dram_hash #(
  parameter int num_vcache_rows_p            = `MC_NUM_VCACHE_ROWS,
  parameter int vcache_block_size_in_words_p = `MC_VCACHE_BLOCK_WORDS
) (
  input  logic [`MC_DATA_WIDTH-1:0]       eva_i,
  input  logic [`MC_POD_X_CORD_WIDTH-1:0] pod_x_i,
  input  logic [`MC_POD_Y_CORD_WIDTH-1:0] pod_y_i,
  output logic [`MC_ADDR_WIDTH-1:0]       epa_o,
  output logic [`MC_X_CORD_WIDTH-1:0]     x_cord_o,
  output logic [`MC_Y_CORD_WIDTH-1:0]     y_cord_o
);

  // one offset bit is kept even for single word lines.
  localparam int word_offset_width_lp = (vcache_block_size_in_words_p > 1)
    ? $clog2(vcache_block_size_in_words_p) : 1;
  // north and south rows share one row id, its lsb picks the side.
  localparam int row_id_width_lp = $clog2(2 * num_vcache_rows_p);

  localparam int x_subcord_lsb_lp = 2 + word_offset_width_lp;
  localparam int row_id_lsb_lp    = x_subcord_lsb_lp + `MC_X_SUBCORD_WIDTH;
  localparam int index_lsb_lp     = row_id_lsb_lp + row_id_width_lp;
  // bit 31 only marks DRAM space and is not part of the index.
  localparam int index_width_lp   = `MC_DATA_WIDTH - 1 - index_lsb_lp;

  logic [word_offset_width_lp-1:0]     word_offset;
  logic [`MC_X_SUBCORD_WIDTH-1:0]      x_subcord;
  logic [row_id_width_lp-1:0]          row_id;
  logic [index_width_lp-1:0]           dram_index;
  logic [`MC_Y_SUBCORD_WIDTH-1:0]      y_subcord;
  logic [`MC_POD_Y_CORD_WIDTH-1:0]     dram_pod_y;

  // lines stripe over columns first, then over the two sides.
  assign word_offset = eva_i[2+:word_offset_width_lp];
  assign x_subcord   = eva_i[x_subcord_lsb_lp+:`MC_X_SUBCORD_WIDTH];
  assign row_id      = eva_i[row_id_lsb_lp+:row_id_width_lp];
  assign dram_index  = eva_i[index_lsb_lp+:index_width_lp];

  // south pod for odd row ids, north pod otherwise.
  assign dram_pod_y = row_id[0]
    ? `MC_POD_Y_CORD_WIDTH'(pod_y_i + 1'b1)
    : `MC_POD_Y_CORD_WIDTH'(pod_y_i - 1'b1);

  if (num_vcache_rows_p == 1) begin : g_one_row
    // south row sits at subcord 0, north row at the last subcord.
    assign y_subcord = {`MC_Y_SUBCORD_WIDTH{~row_id[0]}};
  end else begin : g_multi_row
    // upper row id bits walk from the inner rows outwards.
    assign y_subcord = {
      {(`MC_Y_SUBCORD_WIDTH + 1 - row_id_width_lp){~row_id[0]}},
      (row_id[0] ? row_id[row_id_width_lp-1:1] : ~row_id[row_id_width_lp-1:1])
    };
  end

  assign x_cord_o = {pod_x_i, x_subcord};
  assign y_cord_o = {dram_pod_y, y_subcord};
  assign epa_o    = `MC_ADDR_WIDTH'({dram_index, word_offset});

  // geometry must leave room for an index within the word address.
  initial begin
    assert (index_width_lp > 0)
      else $fatal(1, "mc_dram_hash: geometry leaves no dram index bits");
    assert (index_width_lp + word_offset_width_lp <= `MC_ADDR_WIDTH)
      else $fatal(1, "mc_dram_hash: dram address exceeds the word address");
  end

endmodule

// ==== design/mc_eva_decode.sv ====
// EVA class decode
`include "mc_defs.svh"

module mc_eva_decode (
  input  logic [`MC_DATA_WIDTH-1:0]   eva_i,
  input  logic [`MC_X_CORD_WIDTH-1:0] tg_origin_x_i,
  input  logic [`MC_Y_CORD_WIDTH-1:0] tg_origin_y_i,
  output mc_pkg::eva_class_e          class_o,
  output logic [`MC_ADDR_WIDTH-1:0]   epa_o,
  output logic [`MC_X_CORD_WIDTH-1:0] x_cord_o,
  output logic [`MC_Y_CORD_WIDTH-1:0] y_cord_o
);

  // tile-group offsets reach at most one pod.
  localparam int tg_off_width_lp = 4;
  // word address inside a tile, bits 15:2 of the EVA.
  localparam int word_addr_width_lp = 14;

  localparam int global_x_lsb_lp = 16;
  localparam int global_y_lsb_lp = global_x_lsb_lp + `MC_X_CORD_WIDTH;
  localparam int tg_x_lsb_lp     = 20;
  localparam int tg_y_lsb_lp     = tg_x_lsb_lp + tg_off_width_lp;

  logic [word_addr_width_lp-1:0]   word_addr;
  logic [`MC_X_CORD_WIDTH-1:0]     global_x;
  logic [`MC_Y_CORD_WIDTH-1:0]     global_y;
  logic [tg_off_width_lp-1:0]      tg_x_off;
  logic [tg_off_width_lp-1:0]      tg_y_off;
  logic [`MC_X_CORD_WIDTH-1:0]     tg_x;
  logic [`MC_Y_CORD_WIDTH-1:0]     tg_y;

  assign word_addr = eva_i[2+:word_addr_width_lp];
  assign global_x  = eva_i[global_x_lsb_lp+:`MC_X_CORD_WIDTH];
  assign global_y  = eva_i[global_y_lsb_lp+:`MC_Y_CORD_WIDTH];
  assign tg_x_off  = eva_i[tg_x_lsb_lp+:tg_off_width_lp];
  assign tg_y_off  = eva_i[tg_y_lsb_lp+:tg_off_width_lp];

  // tile-group coordinates wrap around the full mesh.
  assign tg_x = tg_origin_x_i + `MC_X_CORD_WIDTH'(tg_x_off);
  assign tg_y = tg_origin_y_i + `MC_Y_CORD_WIDTH'(tg_y_off);

  // priority on the leading one of the top three bits.
  always_comb begin
    if (eva_i[`MC_DATA_WIDTH-1]) begin
      class_o = mc_pkg::e_class_dram;
    end else if (eva_i[`MC_DATA_WIDTH-2]) begin
      class_o = mc_pkg::e_class_global;
    end else if (eva_i[`MC_DATA_WIDTH-3]) begin
      class_o = mc_pkg::e_class_tile_group;
    end else begin
      class_o = mc_pkg::e_class_local;
    end
  end

  // global mapping doubles as the default for dram and local.
  always_comb begin
    epa_o = `MC_ADDR_WIDTH'(word_addr);
    if (class_o == mc_pkg::e_class_tile_group) begin
      x_cord_o = tg_x;
      y_cord_o = tg_y;
    end else begin
      x_cord_o = global_x;
      y_cord_o = global_y;
    end
  end

  // a known address always yields a known class.
  always_comb begin
    if (!$isunknown(eva_i)) begin
      assert (!$isunknown(class_o))
        else $error("mc_eva_decode: unknown class for known eva %h", eva_i);
    end
  end

endmodule

// ==== design/mc_eva_xlate.sv ====
// EVA to NPA translation
`include "mc_defs.svh"

module mc_eva_xlate (
  input  logic                            clk_i,
  input  logic                            rst_n_i,

  input  logic                            v_i,
  input  logic [`MC_DATA_WIDTH-1:0]       eva_i,
  input  mc_pkg::op_e                     op_i,
  input  logic [`MC_DATA_WIDTH-1:0]       data_i,

  input  logic [`MC_POD_X_CORD_WIDTH-1:0] pod_x_i,
  input  logic [`MC_POD_Y_CORD_WIDTH-1:0] pod_y_i,
  input  logic [`MC_X_CORD_WIDTH-1:0]     tg_origin_x_i,
  input  logic [`MC_Y_CORD_WIDTH-1:0]     tg_origin_y_i,

  output logic                            v_o,
  output mc_pkg::op_e                     op_o,
  output logic [`MC_DATA_WIDTH-1:0]       data_o,
  output logic [`MC_ADDR_WIDTH-1:0]       epa_o,
  output logic [`MC_X_CORD_WIDTH-1:0]     x_cord_o,
  output logic [`MC_Y_CORD_WIDTH-1:0]     y_cord_o,
  output mc_pkg::eva_class_e              class_o,

  output logic                            local_v_o,
  output logic [13:0]                     local_addr_o
);

  logic                            is_local;
  mc_pkg::eva_class_e              dec_class;
  logic [`MC_ADDR_WIDTH-1:0]       dec_epa;
  logic [`MC_X_CORD_WIDTH-1:0]     dec_x;
  logic [`MC_Y_CORD_WIDTH-1:0]     dec_y;
  logic [`MC_ADDR_WIDTH-1:0]       hash_epa;
  logic [`MC_X_CORD_WIDTH-1:0]     hash_x;
  logic [`MC_Y_CORD_WIDTH-1:0]     hash_y;
  logic [`MC_ADDR_WIDTH-1:0]       sel_epa;
  logic [`MC_X_CORD_WIDTH-1:0]     sel_x;
  logic [`MC_Y_CORD_WIDTH-1:0]     sel_y;

  mc_eva_decode u_mc_eva_decode (
    .eva_i         (eva_i),
    .tg_origin_x_i (tg_origin_x_i),
    .tg_origin_y_i (tg_origin_y_i),
    .class_o       (dec_class),
    .epa_o         (dec_epa),
    .x_cord_o      (dec_x),
    .y_cord_o      (dec_y)
  );

  mc_dram_hash #(
    .num_vcache_rows_p            (`MC_NUM_VCACHE_ROWS),
    .vcache_block_size_in_words_p (`MC_VCACHE_BLOCK_WORDS)
  ) u_mc_dram_hash (
    .eva_i    (eva_i),
    .pod_x_i  (pod_x_i),
    .pod_y_i  (pod_y_i),
    .epa_o    (hash_epa),
    .x_cord_o (hash_x),
    .y_cord_o (hash_y)
  );

  assign is_local = (dec_class == mc_pkg::e_class_local);

  // dram space takes the hashed address.
  always_comb begin
    if (dec_class == mc_pkg::e_class_dram) begin
      sel_epa = hash_epa;
      sel_x   = hash_x;
      sel_y   = hash_y;
    end else begin
      sel_epa = dec_epa;
      sel_x   = dec_x;
      sel_y   = dec_y;
    end
  end

  // exactly one valid follows each strobe.
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      v_o       <= 1'b0;
      local_v_o <= 1'b0;
    end else begin
      v_o       <= v_i & ~is_local;
      local_v_o <= v_i & is_local;
    end
  end

  // request fields hold until the next strobe.
  always_ff @(posedge clk_i) begin
    if (v_i) begin
      op_o         <= op_i;
      data_o       <= data_i;
      epa_o        <= sel_epa;
      x_cord_o     <= sel_x;
      y_cord_o     <= sel_y;
      class_o      <= dec_class;
      local_addr_o <= eva_i[15:2];
    end
  end

  // local and network paths never fire together.
  assert property (@(posedge clk_i) disable iff (!rst_n_i) !(v_o && local_v_o))
    else $error("mc_eva_xlate: v_o and local_v_o high together");

  // a reset cycle leaves both paths idle.
  assert property (@(posedge clk_i) !rst_n_i |=> !v_o && !local_v_o)
    else $error("mc_eva_xlate: valid high after reset");

endmodule

// ==== design/mc_pkg.sv ====
// Address translation types
package mc_pkg;

  // class of a remote EVA, taken from its top bits.
  typedef enum logic [1:0] {
    e_class_local      = 2'b00,
    e_class_tile_group = 2'b01,
    e_class_global     = 2'b10,
    e_class_dram       = 2'b11
  } eva_class_e;

  // remote request operation.
  typedef enum logic {
    e_op_load  = 1'b0,
    e_op_store = 1'b1
  } op_e;

endpackage

// ==== run.sh ====
#!/bin/sh
# build and run the EVA translation testbench with Verilator
log=sim.log
rm -f "$log"

verilator --binary --timing --assert -f tb.f --top-module tb_eva_xlate \
  -o tb_eva_xlate > "$log" 2>&1 &&
  ./obj_dir/tb_eva_xlate >> "$log" 2>&1 ||
  { cat "$log"; echo "build or simulation error"; exit 1; }

cat "$log"
grep -q "sim failed" "$log" && { echo "run failed"; exit 1; }
echo "run completed"
exit 0

// ==== tb.f ====
+incdir+design
design/mc_pkg.sv
design/mc_dram_hash.sv
design/mc_eva_decode.sv
design/mc_eva_xlate.sv
verif/tb_eva_xlate.sv

// ==== verif/tb_eva_xlate.sv ====
// EVA translation testbench
`include "mc_defs.svh"

module tb_eva_xlate;

  localparam int reset_cycles_lp = 4;
  localparam int num_cycles_lp   = 2000;
  localparam int v_percent_lp    = 70;
  // reset, traffic and drain, plus a margin.
  localparam int timeout_cycles_lp = reset_cycles_lp + num_cycles_lp + 96;

  logic                            clk_i;
  logic                            rst_n_i;
  logic                            v_i;
  logic [`MC_DATA_WIDTH-1:0]       eva_i;
  mc_pkg::op_e                     op_i;
  logic [`MC_DATA_WIDTH-1:0]       data_i;
  logic [`MC_POD_X_CORD_WIDTH-1:0] pod_x_i;
  logic [`MC_POD_Y_CORD_WIDTH-1:0] pod_y_i;
  logic [`MC_X_CORD_WIDTH-1:0]     tg_origin_x_i;
  logic [`MC_Y_CORD_WIDTH-1:0]     tg_origin_y_i;

  logic                            v_o;
  mc_pkg::op_e                     op_o;
  logic [`MC_DATA_WIDTH-1:0]       data_o;
  logic [`MC_ADDR_WIDTH-1:0]       epa_o;
  logic [`MC_X_CORD_WIDTH-1:0]     x_cord_o;
  logic [`MC_Y_CORD_WIDTH-1:0]     y_cord_o;
  mc_pkg::eva_class_e              class_o;
  logic                            local_v_o;
  logic [13:0]                     local_addr_o;

  // expected response to the request in flight.
  logic                            exp_v;
  logic                            exp_local_v;
  mc_pkg::op_e                     exp_op;
  logic [`MC_DATA_WIDTH-1:0]       exp_data;
  logic [`MC_ADDR_WIDTH-1:0]       exp_epa;
  logic [`MC_X_CORD_WIDTH-1:0]     exp_x;
  logic [`MC_Y_CORD_WIDTH-1:0]     exp_y;
  mc_pkg::eva_class_e              exp_class;
  logic [13:0]                     exp_local_addr;

  int          errors;
  int          cycle_count;
  int unsigned seed_val;

  mc_eva_xlate u_mc_eva_xlate (
    .clk_i         (clk_i),
    .rst_n_i       (rst_n_i),
    .v_i           (v_i),
    .eva_i         (eva_i),
    .op_i          (op_i),
    .data_i        (data_i),
    .pod_x_i       (pod_x_i),
    .pod_y_i       (pod_y_i),
    .tg_origin_x_i (tg_origin_x_i),
    .tg_origin_y_i (tg_origin_y_i),
    .v_o           (v_o),
    .op_o          (op_o),
    .data_o        (data_o),
    .epa_o         (epa_o),
    .x_cord_o      (x_cord_o),
    .y_cord_o      (y_cord_o),
    .class_o       (class_o),
    .local_v_o     (local_v_o),
    .local_addr_o  (local_addr_o)
  );

  initial begin
    clk_i = 1'b0;
    forever #50 clk_i = ~clk_i;
  end

  // run limit.
  always @(posedge clk_i) begin
    cycle_count = cycle_count + 1;
    if (cycle_count >= timeout_cycles_lp) begin
      $display("timeout: run did not finish within %0d cycles", timeout_cycles_lp);
      $display("errors: %0d", errors);
      $display("sim failed");
      $finish;
    end
  end

  task automatic report_mismatch(input string name, input logic [31:0] expv,
                                 input logic [31:0] actv);
    errors = errors + 1;
    $display("[ERROR] t=%0t %s expected %h actual %h", $time, name, expv, actv);
  endtask

  // reference model, straight from the EVA map and the DRAM hash rule.
  task automatic model_request(input logic [31:0] eva, input mc_pkg::op_e op,
                               input logic [31:0] data);
    logic [3:0] dram_pod_y;
    exp_op         = op;
    exp_data       = data;
    exp_local_addr = eva[15:2];
    exp_epa        = {14'd0, eva[15:2]};
    exp_x          = '0;
    exp_y          = '0;
    if (eva[31]) begin
      exp_class = mc_pkg::e_class_dram;
      exp_epa   = {4'd0, eva[30:10], eva[4:2]};
      exp_x     = {pod_x_i, eva[8:5]};
      if (eva[9]) begin
        dram_pod_y = pod_y_i + 4'd1;
        exp_y      = {dram_pod_y, 3'b000};
      end else begin
        dram_pod_y = pod_y_i - 4'd1;
        exp_y      = {dram_pod_y, 3'b111};
      end
    end else if (eva[30]) begin
      exp_class = mc_pkg::e_class_global;
      exp_y     = eva[29:23];
      exp_x     = eva[22:16];
    end else if (eva[29]) begin
      exp_class = mc_pkg::e_class_tile_group;
      exp_y     = tg_origin_y_i + {3'b000, eva[27:24]};
      exp_x     = tg_origin_x_i + {3'b000, eva[23:20]};
    end else begin
      exp_class = mc_pkg::e_class_local;
    end
    exp_v       = (exp_class != mc_pkg::e_class_local);
    exp_local_v = (exp_class == mc_pkg::e_class_local);
  endtask

  // one cycle of traffic, the eva biased evenly over the four classes.
  task automatic drive_request();
    logic [31:0]  eva;
    logic [31:0]  data;
    logic [31:0]  r;
    int unsigned  pick;
    r    = $urandom;
    data = $urandom;
    pick = $urandom_range(3, 0);
    eva  = r;
    case (pick)
      0: eva[31] = 1'b1;
      1: eva[31:30] = 2'b01;
      2: eva[31:29] = 3'b001;
      default: eva[31:29] = 3'b000;
    endcase
    eva_i  = eva;
    data_i = data;
    op_i   = mc_pkg::op_e'(r[0] ^ r[13]);
    v_i    = ($urandom_range(99, 0) < v_percent_lp);
    if (v_i) begin
      model_request(eva, op_i, data);
    end else begin
      exp_v       = 1'b0;
      exp_local_v = 1'b0;
    end
  endtask

  task automatic check_outputs();
    if (v_o !== exp_v) report_mismatch("v_o", 32'(exp_v), 32'(v_o));
    if (local_v_o !== exp_local_v) report_mismatch("local_v_o", 32'(exp_local_v), 32'(local_v_o));
    if (exp_v) begin
      if (class_o !== exp_class) report_mismatch("class_o", 32'(exp_class), 32'(class_o));
      if (op_o !== exp_op) report_mismatch("op_o", 32'(exp_op), 32'(op_o));
      if (data_o !== exp_data) report_mismatch("data_o", exp_data, data_o);
      if (epa_o !== exp_epa) report_mismatch("epa_o", 32'(exp_epa), 32'(epa_o));
      if (x_cord_o !== exp_x) report_mismatch("x_cord_o", 32'(exp_x), 32'(x_cord_o));
      if (y_cord_o !== exp_y) report_mismatch("y_cord_o", 32'(exp_y), 32'(y_cord_o));
    end
    if (exp_local_v) begin
      if (local_addr_o !== exp_local_addr) begin
        report_mismatch("local_addr_o", 32'(exp_local_addr), 32'(local_addr_o));
      end
    end
  endtask

  initial begin
    logic [31:0] cfg;
    errors      = 0;
    cycle_count = 0;
    seed_val    = 32'h23f7;
    rst_n_i     = 1'b0;
    v_i         = 1'b0;
    eva_i       = '0;
    op_i        = mc_pkg::e_op_load;
    data_i      = '0;
    exp_v       = 1'b0;
    exp_local_v = 1'b0;
    cfg           = $urandom(seed_val);
    pod_x_i       = cfg[2:0];
    pod_y_i       = cfg[6:3];
    tg_origin_x_i = cfg[13:7];
    tg_origin_y_i = cfg[20:14];

    // strobes during reset, local and dram in turn, must reach neither valid.
    for (int i = 0; i < reset_cycles_lp; i++) begin
      v_i   = 1'b1;
      eva_i = i[0] ? 32'h8000_0000 : 32'h0000_0000;
      @(negedge clk_i);
      check_outputs();
    end
    rst_n_i = 1'b1;

    for (int i = 0; i < num_cycles_lp; i++) begin
      // pod y at both ends checks the north and south wrap.
      if (i == num_cycles_lp / 3) pod_y_i = 4'h0;
      if (i == 2 * num_cycles_lp / 3) pod_y_i = 4'hf;
      drive_request();
      @(negedge clk_i);
      check_outputs();
    end

    v_i         = 1'b0;
    exp_v       = 1'b0;
    exp_local_v = 1'b0;
    @(negedge clk_i);
    check_outputs();

    $display("errors: %0d", errors);
    if (errors == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

endmodule
